// File: design/wi_defines.svh
`ifndef WI_DEFINES_SVH
`define WI_DEFINES_SVH

// Datapath widths
`define WI_WORD_W      32
`define WI_REG_IDX_W   5
`define WI_NUM_REGS    32
`define WI_OPC_W       6
`define WI_LANES       4

// Byte-enable patterns per access width
`define WI_LANES_WORD  4'hF
`define WI_LANES_HALF  4'hC
`define WI_LANES_BYTE  4'h8

// NOP encoding, used at reset and for bubbles
`define WI_INST_RESET  32'h0400_0000

// Opcodes
`define WI_OPC_HALT     6'b000000
`define WI_OPC_NOP      6'b000001
`define WI_OPC_RTYPE    6'b110110
`define WI_OPC_ADDI     6'b010000
`define WI_OPC_LD_CLASS 4'b1000
`define WI_OPC_ST_CLASS 4'b1001

`endif

// File: design/wi_pkg.sv
`include "wi_defines.svh"

package wi_pkg;

   // Plain vectors with a meaning
   typedef logic [`WI_WORD_W-1:0]    word_t;
   typedef logic [`WI_WORD_W-1:0]    pc_t;
   typedef logic [`WI_WORD_W-1:0]    inst_t;
   typedef logic [`WI_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`WI_LANES-1:0]     lane_mask_t;

   // R-type function, taken from instruction bits 1:0
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_XOR = 2'b10,
      ALU_AND = 2'b11
   } alu_op_t;

   // Access width, from opcode bits 1:0 of a load or store
   typedef enum logic [1:0] {
      GRAN_WORD = 2'b00,
      GRAN_BYTE = 2'b01,
      GRAN_HALF = 2'b10,
      GRAN_BAD  = 2'b11
   } mem_gran_t;

   // Source of an execute operand
   typedef enum logic [1:0] {
      FWD_REG   = 2'b00,
      FWD_EXMEM = 2'b01,
      FWD_MEMWB = 2'b10
   } fwd_sel_t;

endpackage

// File: design/inst_decoder.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module inst_decoder
   import wi_pkg::*;
(
   input  inst_t     inst_i,
   output logic      reg_write_o,
   output logic      mem_read_o,
   output logic      mem_write_o,
   output logic      mem_to_reg_o,
   output logic      alu_src_imm_o,
   output logic      halt_o,
   output logic      dec_err_o,
   output alu_op_t   alu_op_o,
   output mem_gran_t mem_gran_o,
   output reg_idx_t  dest_o
);

   logic [`WI_OPC_W-1:0] opcode;
   logic                 is_load;
   logic                 is_store;

   assign opcode   = inst_i[31:26];
   assign is_load  = (opcode[5:2] == `WI_OPC_LD_CLASS);
   assign is_store = (opcode[5:2] == `WI_OPC_ST_CLASS);

   // R-type writes rd, ADDI and loads write rt
   assign dest_o = (opcode == `WI_OPC_RTYPE) ? inst_i[15:11] : inst_i[20:16];

   always_comb begin
      reg_write_o   = 1'b0;
      mem_read_o    = 1'b0;
      mem_write_o   = 1'b0;
      mem_to_reg_o  = 1'b0;
      alu_src_imm_o = 1'b0;
      halt_o        = 1'b0;
      dec_err_o     = 1'b0;
      alu_op_o      = ALU_ADD;
      mem_gran_o    = GRAN_WORD;
      if (is_load) begin
         reg_write_o   = 1'b1;
         mem_read_o    = 1'b1;
         mem_to_reg_o  = 1'b1;
         alu_src_imm_o = 1'b1;
         mem_gran_o    = mem_gran_t'(opcode[1:0]);
      end else if (is_store) begin
         // Width check happens later, in the memory stage
         mem_write_o   = 1'b1;
         alu_src_imm_o = 1'b1;
         mem_gran_o    = mem_gran_t'(opcode[1:0]);
      end else begin
         case (opcode)
            `WI_OPC_HALT:  halt_o = 1'b1;
            `WI_OPC_NOP:   dec_err_o = 1'b0;
            `WI_OPC_RTYPE: begin
               reg_write_o = 1'b1;
               alu_op_o    = alu_op_t'(inst_i[1:0]);
            end
            `WI_OPC_ADDI: begin
               reg_write_o   = 1'b1;
               alu_src_imm_o = 1'b1;
            end
            default:       dec_err_o = 1'b1;
         endcase
      end
   end

endmodule

// File: design/reg_file.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module reg_file
   import wi_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  reg_idx_t rd_a_i,
   input  reg_idx_t rd_b_i,
   input  logic     wr_en_i,
   input  reg_idx_t wr_idx_i,
   input  word_t    wr_data_i,
   output word_t    rd_a_o,
   output word_t    rd_b_o
);

   word_t regs [`WI_NUM_REGS];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `WI_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en_i) begin
         regs[wr_idx_i] <= wr_data_i;
      end
   end

   // Write-through bypass
   // a decode read of the register being written back sees the new value
   assign rd_a_o = (wr_en_i && (wr_idx_i == rd_a_i)) ? wr_data_i : regs[rd_a_i];
   assign rd_b_o = (wr_en_i && (wr_idx_i == rd_b_i)) ? wr_data_i : regs[rd_b_i];

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
   import wi_pkg::*;
(
   input  reg_idx_t id_rs_i,
   input  reg_idx_t id_rt_i,
   input  logic     ex_mem_read_i,
   input  reg_idx_t ex_dest_i,
   input  reg_idx_t ex_rs_i,
   input  reg_idx_t ex_rt_i,
   input  logic     exmem_reg_write_i,
   input  reg_idx_t exmem_dest_i,
   input  logic     memwb_reg_write_i,
   input  reg_idx_t memwb_dest_i,
   output logic     stall_o,
   output fwd_sel_t fwd_a_o,
   output fwd_sel_t fwd_b_o
);

   // Youngest producer wins, so EX/MEM is checked before MEM/WB
   function automatic fwd_sel_t pick_src(
      input reg_idx_t src,
      input logic     exmem_we,
      input reg_idx_t exmem_dest,
      input logic     memwb_we,
      input reg_idx_t memwb_dest
   );
      fwd_sel_t sel;
      if (exmem_we && (exmem_dest == src)) begin
         sel = FWD_EXMEM;
      end else if (memwb_we && (memwb_dest == src)) begin
         sel = FWD_MEMWB;
      end else begin
         sel = FWD_REG;
      end
      return sel;
   endfunction

   // Load data is only ready after the memory stage
   assign stall_o = ex_mem_read_i &&
                    ((ex_dest_i == id_rs_i) || (ex_dest_i == id_rt_i));

   assign fwd_a_o = pick_src(ex_rs_i, exmem_reg_write_i, exmem_dest_i,
                             memwb_reg_write_i, memwb_dest_i);
   assign fwd_b_o = pick_src(ex_rt_i, exmem_reg_write_i, exmem_dest_i,
                             memwb_reg_write_i, memwb_dest_i);

endmodule

// File: design/mem_access.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module mem_access
   import wi_pkg::*;
(
   input  logic       mem_read_i,
   input  logic       mem_write_i,
   input  mem_gran_t  mem_gran_i,
   input  word_t      rd_data_i,
   output lane_mask_t we_o,
   output lane_mask_t re_o,
   output word_t      load_data_o,
   output logic       gran_err_o
);

   lane_mask_t lanes;

   // Lane pattern per width, nothing for the unsupported one
   always_comb begin
      case (mem_gran_i)
         GRAN_WORD: lanes = `WI_LANES_WORD;
         GRAN_HALF: lanes = `WI_LANES_HALF;
         GRAN_BYTE: lanes = `WI_LANES_BYTE;
         default:   lanes = '0;
      endcase
   end

   assign we_o = mem_write_i ? lanes : '0;
   assign re_o = mem_read_i  ? lanes : '0;

   // Narrow loads keep the low bits, zero above
   always_comb begin
      case (mem_gran_i)
         GRAN_WORD: load_data_o = rd_data_i;
         GRAN_HALF: load_data_o = word_t'(rd_data_i[15:0]);
         GRAN_BYTE: load_data_o = word_t'(rd_data_i[7:0]);
         default:   load_data_o = '0;
      endcase
   end

   assign gran_err_o = (mem_read_i || mem_write_i) && (mem_gran_i == GRAN_BAD);

endmodule

// File: design/wi_pipe.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module wi_pipe
   import wi_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  inst_t      inst_i,
   input  word_t      data_mem_to_proc_i,
   output pc_t        iaddr_o,
   output word_t      daddr_o,
   output lane_mask_t we_o,
   output lane_mask_t re_o,
   output word_t      data_proc_to_mem_o,
   output logic       err_o,
   output logic       halt_o
);

   // Fetch
   pc_t       pc_q;
   inst_t     ifid_inst;
   logic      hold_fetch;
   // Decode
   logic      dec_reg_write, dec_mem_read, dec_mem_write, dec_mem_to_reg;
   logic      dec_alu_src_imm, dec_halt, dec_err, stall;
   alu_op_t   dec_alu_op;
   mem_gran_t dec_gran;
   reg_idx_t  dec_dest;
   word_t     rf_a, rf_b, dec_imm;
   // Execute
   logic      idex_reg_write, idex_mem_read, idex_mem_write, idex_mem_to_reg;
   logic      idex_alu_src_imm, idex_halt;
   alu_op_t   idex_alu_op;
   mem_gran_t idex_gran;
   word_t     idex_a, idex_b, idex_imm;
   reg_idx_t  idex_rs, idex_rt, idex_dest;
   fwd_sel_t  fwd_a, fwd_b;
   word_t     ex_a, ex_b, alu_b, alu_res;
   // Memory
   logic      exmem_reg_write, exmem_mem_read, exmem_mem_write, exmem_mem_to_reg;
   logic      exmem_halt, gran_err;
   mem_gran_t exmem_gran;
   word_t     exmem_alu, exmem_st_data, load_data;
   reg_idx_t  exmem_dest;
   // Writeback
   logic      memwb_reg_write, memwb_mem_to_reg, memwb_halt;
   word_t     memwb_load, memwb_alu, wb_data;
   reg_idx_t  memwb_dest;

   function automatic word_t operand_mux(input fwd_sel_t sel, input word_t reg_val,
                                         input word_t exmem_val, input word_t memwb_val);
      word_t val;
      case (sel)
         FWD_EXMEM: val = exmem_val;
         FWD_MEMWB: val = memwb_val;
         default:   val = reg_val;
      endcase
      return val;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Fetch

   // HALT in decode freezes fetch for good, a stall for one cycle
   assign hold_fetch = stall | dec_halt;
   assign iaddr_o    = pc_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q      <= '0;
         ifid_inst <= `WI_INST_RESET;
      end else if (!hold_fetch) begin
         pc_q      <= pc_q + pc_t'(4);
         ifid_inst <= inst_i;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Decode

   inst_decoder inst_decoder_inst (
      .inst_i(ifid_inst), .reg_write_o(dec_reg_write), .mem_read_o(dec_mem_read),
      .mem_write_o(dec_mem_write), .mem_to_reg_o(dec_mem_to_reg),
      .alu_src_imm_o(dec_alu_src_imm), .halt_o(dec_halt), .dec_err_o(dec_err),
      .alu_op_o(dec_alu_op), .mem_gran_o(dec_gran), .dest_o(dec_dest)
   );

   reg_file reg_file_inst (
      .clk(clk), .rst_n(rst_n), .rd_a_i(ifid_inst[25:21]), .rd_b_i(ifid_inst[20:16]),
      .wr_en_i(memwb_reg_write), .wr_idx_i(memwb_dest), .wr_data_i(wb_data),
      .rd_a_o(rf_a), .rd_b_o(rf_b)
   );

   assign dec_imm = {{(`WI_WORD_W-16){ifid_inst[15]}}, ifid_inst[15:0]};

   // Stall squashes everything with a side effect into a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idex_reg_write   <= 1'b0;
         idex_mem_read    <= 1'b0;
         idex_mem_write   <= 1'b0;
         idex_mem_to_reg  <= 1'b0;
         idex_alu_src_imm <= 1'b0;
         idex_halt        <= 1'b0;
         idex_alu_op      <= ALU_ADD;
         idex_gran        <= GRAN_WORD;
      end else begin
         idex_reg_write   <= dec_reg_write & ~stall;
         idex_mem_read    <= dec_mem_read & ~stall;
         idex_mem_write   <= dec_mem_write & ~stall;
         idex_mem_to_reg  <= dec_mem_to_reg & ~stall;
         idex_alu_src_imm <= dec_alu_src_imm;
         idex_halt        <= dec_halt & ~stall;
         idex_alu_op      <= dec_alu_op;
         idex_gran        <= dec_gran;
      end
   end

   always_ff @(posedge clk) begin
      idex_a    <= rf_a;
      idex_b    <= rf_b;
      idex_imm  <= dec_imm;
      idex_rs   <= ifid_inst[25:21];
      idex_rt   <= ifid_inst[20:16];
      idex_dest <= dec_dest;
   end

   hazard_unit hazard_unit_inst (
      .id_rs_i(ifid_inst[25:21]), .id_rt_i(ifid_inst[20:16]),
      .ex_mem_read_i(idex_mem_read), .ex_dest_i(idex_dest),
      .ex_rs_i(idex_rs), .ex_rt_i(idex_rt),
      .exmem_reg_write_i(exmem_reg_write), .exmem_dest_i(exmem_dest),
      .memwb_reg_write_i(memwb_reg_write), .memwb_dest_i(memwb_dest),
      .stall_o(stall), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Execute

   assign ex_a  = operand_mux(fwd_a, idex_a, exmem_alu, wb_data);
   assign ex_b  = operand_mux(fwd_b, idex_b, exmem_alu, wb_data);
   assign alu_b = idex_alu_src_imm ? idex_imm : ex_b;

   always_comb begin
      case (idex_alu_op)
         ALU_SUB: alu_res = ex_a - alu_b;
         ALU_XOR: alu_res = ex_a ^ alu_b;
         ALU_AND: alu_res = ex_a & alu_b;
         default: alu_res = ex_a + alu_b;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         exmem_reg_write  <= 1'b0;
         exmem_mem_read   <= 1'b0;
         exmem_mem_write  <= 1'b0;
         exmem_mem_to_reg <= 1'b0;
         exmem_halt       <= 1'b0;
         exmem_gran       <= GRAN_WORD;
      end else begin
         exmem_reg_write  <= idex_reg_write;
         exmem_mem_read   <= idex_mem_read;
         exmem_mem_write  <= idex_mem_write;
         exmem_mem_to_reg <= idex_mem_to_reg;
         exmem_halt       <= idex_halt;
         exmem_gran       <= idex_gran;
      end
   end

   // Store data is rt after forwarding
   always_ff @(posedge clk) begin
      exmem_alu     <= alu_res;
      exmem_st_data <= ex_b;
      exmem_dest    <= idex_dest;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memory and writeback

   assign daddr_o            = exmem_alu;
   assign data_proc_to_mem_o = exmem_st_data;

   mem_access mem_access_inst (
      .mem_read_i(exmem_mem_read), .mem_write_i(exmem_mem_write),
      .mem_gran_i(exmem_gran), .rd_data_i(data_mem_to_proc_i),
      .we_o(we_o), .re_o(re_o), .load_data_o(load_data), .gran_err_o(gran_err)
   );

   // A bad-width load must not reach the register file
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         memwb_reg_write  <= 1'b0;
         memwb_mem_to_reg <= 1'b0;
         memwb_halt       <= 1'b0;
      end else begin
         memwb_reg_write  <= exmem_reg_write & ~gran_err;
         memwb_mem_to_reg <= exmem_mem_to_reg;
         memwb_halt       <= memwb_halt | exmem_halt;
      end
   end

   always_ff @(posedge clk) begin
      memwb_load <= load_data;
      memwb_alu  <= exmem_alu;
      memwb_dest <= exmem_dest;
   end

   assign wb_data = memwb_mem_to_reg ? memwb_load : memwb_alu;
   assign halt_o  = memwb_halt;
   assign err_o   = dec_err | gran_err;

endmodule

// File: tb/wi_pipe_assertions.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module wi_pipe_assertions
   import wi_pkg::*;
(
   input logic       clk,
   input logic       rst_n,
   input lane_mask_t we_o,
   input lane_mask_t re_o,
   input logic       err_o,
   input logic       halt_o
);

   int fail_count;

   // One access direction per cycle
   assert property (@(posedge clk) disable iff (!rst_n) !((we_o != '0) && (re_o != '0)))
      else begin
         fail_count++;
         $error("we_o and re_o both active");
      end

   assert property (@(posedge clk) disable iff (!rst_n)
                    (we_o == 4'h0) || (we_o == `WI_LANES_WORD) ||
                    (we_o == `WI_LANES_HALF) || (we_o == `WI_LANES_BYTE))
      else begin
         fail_count++;
         $error("we_o has an illegal lane pattern %h", we_o);
      end

   // Halt is sticky until the next reset
   assert property (@(posedge clk) disable iff (!rst_n) halt_o |=> halt_o)
      else begin
         fail_count++;
         $error("halt_o dropped without a reset");
      end

   assert property (@(posedge clk) !rst_n |-> ((we_o == '0) && (re_o == '0) && !halt_o && !err_o))
      else begin
         fail_count++;
         $error("outputs active during reset");
      end

endmodule

bind wi_pipe wi_pipe_assertions wi_pipe_assertions_inst (
   .clk(clk), .rst_n(rst_n), .we_o(we_o), .re_o(re_o), .err_o(err_o), .halt_o(halt_o)
);

// File: tb/wi_pipe_tb.sv
`timescale 1ns/10ps
`include "wi_defines.svh"

module wi_pipe_tb
   import wi_pkg::*;
();

   localparam logic [5:0] OPC_LW   = {`WI_OPC_LD_CLASS, 2'b00};
   localparam logic [5:0] OPC_LB   = {`WI_OPC_LD_CLASS, 2'b01};
   localparam logic [5:0] OPC_LH   = {`WI_OPC_LD_CLASS, 2'b10};
   localparam logic [5:0] OPC_SW   = {`WI_OPC_ST_CLASS, 2'b00};
   localparam logic [5:0] OPC_SB   = {`WI_OPC_ST_CLASS, 2'b01};
   localparam logic [5:0] OPC_SH   = {`WI_OPC_ST_CLASS, 2'b10};
   localparam logic [5:0] OPC_SBAD = {`WI_OPC_ST_CLASS, 2'b11};
   localparam inst_t      HALT     = 32'h0000_0000;
   localparam word_t      MEM_KEY  = 32'hA5A5_5A5A;

   logic       clk;
   logic       rst_n;
   inst_t      inst_i;
   word_t      data_mem_to_proc_i;
   pc_t        iaddr_o;
   word_t      daddr_o;
   lane_mask_t we_o;
   lane_mask_t re_o;
   word_t      data_proc_to_mem_o;
   logic       err_o;
   logic       halt_o;

   inst_t      imem [64];
   inst_t      prog [$];
   word_t      exp_addr [$];
   word_t      exp_data [$];
   lane_mask_t exp_lanes [$];
   word_t      ld_addr [$];
   lane_mask_t ld_lanes [$];
   int         errors, test_errors, tests_run, tests_failed;
   int         err_cycles, budget_cycles;

   wi_pipe wi_pipe_inst (
      .clk(clk), .rst_n(rst_n), .inst_i(inst_i), .data_mem_to_proc_i(data_mem_to_proc_i),
      .iaddr_o(iaddr_o), .daddr_o(daddr_o), .we_o(we_o), .re_o(re_o),
      .data_proc_to_mem_o(data_proc_to_mem_o), .err_o(err_o), .halt_o(halt_o)
   );

   // Data memory ignores stores so every load sees a fixed pattern
   function automatic word_t mem_word(input word_t addr);
      return addr ^ MEM_KEY;
   endfunction

   assign inst_i             = (iaddr_o[31:8] == '0) ? imem[iaddr_o[7:2]] : HALT;
   assign data_mem_to_proc_i = mem_word(daddr_o);

   function automatic inst_t enc_rtype(input alu_op_t f, input reg_idx_t rd,
                                       input reg_idx_t rs, input reg_idx_t rt);
      return {`WI_OPC_RTYPE, rs, rt, rd, 9'd0, f};
   endfunction

   function automatic inst_t enc_imm(input logic [5:0] opc, input reg_idx_t rt,
                                     input reg_idx_t rs, input logic [15:0] imm);
      return {opc, rs, rt, imm};
   endfunction

   function automatic logic [15:0] rand_imm();
      return 16'($urandom);
   endfunction

   // Positive, 16-byte aligned
   function automatic logic [15:0] rand_offset();
      return {1'b0, 11'($urandom), 4'h0};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Reference model that runs the program one instruction at a time

   function automatic bit model_program();
      word_t      regs [32];
      word_t      a, b, imm, addr, ld;
      inst_t      ins;
      logic [5:0] opc;
      lane_mask_t lanes;
      bit         err;
      err = 1'b0;
      for (int r = 0; r < 32; r++) begin
         regs[r] = '0;
      end
      for (int i = 0; i < prog.size(); i++) begin
         ins  = prog[i];
         opc  = ins[31:26];
         a    = regs[ins[25:21]];
         b    = regs[ins[20:16]];
         imm  = {{16{ins[15]}}, ins[15:0]};
         addr = a + imm;
         ld   = mem_word(addr);
         // Lanes of a load or store by access width
         case (opc[1:0])
            2'b00:   lanes = 4'hF;
            2'b10:   lanes = 4'hC;
            2'b01:   lanes = 4'h8;
            default: lanes = 4'h0;
         endcase
         if (opc == `WI_OPC_HALT) begin
            break;
         end else if (opc[5:2] == `WI_OPC_LD_CLASS) begin
            case (opc[1:0])
               2'b00:   regs[ins[20:16]] = ld;
               2'b10:   regs[ins[20:16]] = {16'h0, ld[15:0]};
               2'b01:   regs[ins[20:16]] = {24'h0, ld[7:0]};
               default: err = 1'b1;
            endcase
            if (lanes != 4'h0) begin
               ld_addr.push_back(addr);
               ld_lanes.push_back(lanes);
            end
         end else if (opc[5:2] == `WI_OPC_ST_CLASS) begin
            if (lanes == 4'h0) begin
               err = 1'b1;
            end else begin
               exp_addr.push_back(addr);
               exp_data.push_back(b);
               exp_lanes.push_back(lanes);
            end
         end else if (opc == `WI_OPC_RTYPE) begin
            case (ins[1:0])
               2'b00:   regs[ins[15:11]] = a + b;
               2'b01:   regs[ins[15:11]] = a - b;
               2'b10:   regs[ins[15:11]] = a ^ b;
               default: regs[ins[15:11]] = a & b;
            endcase
         end else if (opc == `WI_OPC_ADDI) begin
            regs[ins[20:16]] = addr;
         end else if (opc != `WI_OPC_NOP) begin
            err = 1'b1;
         end
      end
      return err;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   task automatic count_error();
      errors++;
      test_errors++;
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         count_error();
      end
   endtask

   task automatic check_lanes(input string name, input lane_mask_t got, input lane_mask_t exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         count_error();
      end
   endtask

   task automatic check_flag(input string name, input bit got, input bit exp);
      if (got !== exp) begin
         $display("FAIL %s: got %h, expected %h", name, got, exp);
         count_error();
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Bus monitor sees the outputs of the cycle that just ended
   initial begin : bus_monitor
      forever begin
         @(posedge clk);
         if (rst_n) begin
            if (err_o) begin
               err_cycles++;
            end
            if (we_o != '0) begin
               if (exp_addr.size() == 0) begin
                  $display("Unexpected store to address %h", daddr_o);
                  count_error();
               end else begin
                  check_word("daddr_o", daddr_o, exp_addr.pop_front());
                  check_word("data_proc_to_mem_o", data_proc_to_mem_o, exp_data.pop_front());
                  check_lanes("we_o", we_o, exp_lanes.pop_front());
               end
            end
            if (re_o != '0) begin
               if (ld_addr.size() == 0) begin
                  $display("Unexpected load from address %h", daddr_o);
                  count_error();
               end else begin
                  check_word("daddr_o", daddr_o, ld_addr.pop_front());
                  check_lanes("re_o", re_o, ld_lanes.pop_front());
               end
            end
         end
      end
   end

   // Budget grows by 4 cycles per instruction plus 20 as each test starts
   initial begin : watchdog
      int cycles;
      cycles = 0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > budget_cycles) begin
            $display("Timeout after %0d cycles, halt_o never rose", cycles);
            $display("sim failed");
            $finish;
         end
      end
   end

   task automatic run_program(input string name);
      bit exp_err;
      int err_start;
      exp_addr.delete();
      exp_data.delete();
      exp_lanes.delete();
      ld_addr.delete();
      ld_lanes.delete();
      exp_err = model_program();
      budget_cycles += 4 * prog.size() + 20;
      test_errors = 0;
      @(negedge clk);
      rst_n = 1'b0;
      for (int i = 0; i < 64; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : HALT;
      end
      repeat (3) @(negedge clk);
      err_start = err_cycles;
      rst_n = 1'b1;
      while (halt_o !== 1'b1) begin
         @(negedge clk);
      end
      // A few more cycles so that stray stores still show up
      repeat (2) @(negedge clk);
      if (exp_addr.size() != 0) begin
         $display("%0d expected stores never appeared", exp_addr.size());
         count_error();
      end
      if (ld_addr.size() != 0) begin
         $display("%0d expected loads never appeared", ld_addr.size());
         count_error();
      end
      check_flag("err_o", err_cycles != err_start, exp_err);
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, test_errors);
         tests_failed++;
      end
      prog.delete();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Programs

   initial begin : main
      void'($urandom(32'h6e24_666d));
      rst_n = 1'b0;
      for (int i = 0; i < 64; i++) begin
         imem[i] = HALT;
      end

      // Each result feeds the next one
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_imm()));
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd2, 5'd0, rand_imm()));
      prog.push_back(enc_rtype(ALU_ADD, 5'd3, 5'd1, 5'd2));
      prog.push_back(enc_rtype(ALU_SUB, 5'd4, 5'd3, 5'd1));
      prog.push_back(enc_rtype(ALU_XOR, 5'd5, 5'd4, 5'd3));
      prog.push_back(enc_rtype(ALU_AND, 5'd6, 5'd5, 5'd4));
      prog.push_back(enc_imm(OPC_SW, 5'd6, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd5, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd4, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd3, 5'd0, rand_offset()));
      prog.push_back(HALT);
      run_program("alu_chain");

      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_imm() & 16'h7FFF));
      prog.push_back(`WI_INST_RESET);
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd2, 5'd1, rand_imm() | 16'h8000));
      prog.push_back(enc_imm(OPC_SW, 5'd2, 5'd0, rand_offset()));
      prog.push_back(HALT);
      run_program("addi_negative");

      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_LW, 5'd2, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_LH, 5'd3, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_LB, 5'd4, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd2, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd3, 5'd0, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd4, 5'd0, rand_offset()));
      prog.push_back(HALT);
      run_program("load_widths");

      // Dependent add right behind the load
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_offset()));
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd5, 5'd0, rand_imm()));
      prog.push_back(enc_imm(OPC_LW, 5'd2, 5'd1, rand_offset()));
      prog.push_back(enc_rtype(ALU_ADD, 5'd3, 5'd2, 5'd5));
      prog.push_back(enc_imm(OPC_SW, 5'd3, 5'd0, rand_offset()));
      prog.push_back(HALT);
      run_program("load_use");

      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_offset()));
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd2, 5'd0, rand_imm()));
      prog.push_back(enc_imm(OPC_SW, 5'd2, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_SH, 5'd2, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_SB, 5'd2, 5'd1, rand_offset()));
      prog.push_back(HALT);
      run_program("store_widths");

      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd1, 5'd0, rand_offset()));
      prog.push_back(enc_imm(`WI_OPC_ADDI, 5'd2, 5'd0, rand_imm()));
      prog.push_back(enc_imm(OPC_SBAD, 5'd2, 5'd1, rand_offset()));
      prog.push_back(enc_imm(OPC_SW, 5'd2, 5'd1, rand_offset()));
      prog.push_back(HALT);
      run_program("bad_width");

      // Failures of the bound checker count as well
      errors += wi_pipe_inst.wi_pipe_assertions_inst.fail_count;

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: build.f
+incdir+design
design/wi_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/hazard_unit.sv
design/mem_access.sv
design/wi_pipe.sv
tb/wi_pipe_assertions.sv
tb/wi_pipe_tb.sv

// File: Makefile
TOP := wi_pipe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

# The log decides the result, a missing summary counts as failure
run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "Simulation did not pass, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
